// ==== filelist.f ====
verilog/lane_pkg.sv
verilog/lane_fifo.sv
verilog/stripe_distributor.sv
verilog/stripe_collector.sv
verilog/lane_buffer_top.sv
tb/tb_clock_gen.sv
tb/lane_buffer_tb.sv

// ==== tb/lane_buffer_tb.sv ====
`timescale 1ns/1ps

module lane_buffer_tb;

  import lane_pkg::*;

  localparam int MAX_CYCLES  = 2000;  // About four times the summed test length.
  localparam int SINK_HOLD   = 0;
  localparam int SINK_RETURN = 1;
  localparam int SINK_RANDOM = 2;

  logic  clk;
  logic  arst_n;
  op_e   i_op;
  data_t i_data;
  logic  i_credit;
  logic  o_valid;
  data_t o_data;
  logic  o_credit;

  data_t exp_q [$];        // Words sent and not yet seen at the output.
  int    src_credits;      // Source model of upstream credits.
  int    sink_owed;        // Credits the sink still has to return.
  int    sink_mode;
  int    rx_count;
  int    stalls;
  int    errors    = 0;
  int    checks    = 0;
  int    cycle_cnt = 0;

  tb_clock_gen tb_clock_gen_inst (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  lane_buffer_top lane_buffer_top_inst (
    .i_clk    (clk),
    .i_arst_n (arst_n),
    .i_op     (i_op),
    .i_data   (i_data),
    .i_credit (i_credit),
    .o_valid  (o_valid),
    .o_data   (o_data),
    .o_credit (o_credit)
  );

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input cred_cnt_t got, input cred_cnt_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // Saturates so that a large miscount cannot wrap onto the expected value.
  function automatic cred_cnt_t clamp_count(input int n);
    if (n < 0 || n >= (1 << CRED_W))
      return '1;
    return cred_cnt_t'(n);
  endfunction

  // Outputs are registered on the rising edge, so they are steady here.
  task automatic observe();
    if (o_credit === 1'b1)
      src_credits++;
    if (o_valid === 1'b1) begin
      rx_count++;
      sink_owed++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected o_valid with no word outstanding at %0t", $time);
      end else begin
        check_data("o_data", o_data, exp_q.pop_front());
      end
    end
  endtask

  // One cycle: sample on the falling edge, then drive the next inputs.
  task automatic tick(input op_e op, input data_t data);
    logic give;
    @(negedge clk);
    observe();
    give = 1'b0;
    if (sink_owed > 0) begin
      if (sink_mode == SINK_RETURN)
        give = 1'b1;
      else if (sink_mode == SINK_RANDOM)
        give = (($urandom % 2) == 0);
    end
    if (give)
      sink_owed--;
    i_credit = give;
    i_op     = op;
    i_data   = data;
    if (op == OP_DATA) begin
      src_credits--;
      exp_q.push_back(data);
    end else if (op == OP_FLUSH) begin
      exp_q.delete();  // Words still in the lanes are dropped.
      src_credits = UP_CREDITS;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) tick(OP_IDLE, '0);
  endtask

  task automatic send_word(input data_t data);
    while (src_credits <= 0) begin
      stalls++;
      tick(OP_IDLE, '0);
    end
    tick(OP_DATA, data);
  endtask

  // Return all credits and wait until every word has come out.
  task automatic drain();
    sink_mode = SINK_RETURN;
    while (exp_q.size() > 0 || sink_owed > 0)
      tick(OP_IDLE, '0);
    idle(3);
    check_count("upstream credits outstanding", clamp_count(UP_CREDITS - src_credits), '0);
  endtask

  task automatic test_reset();
    $display("Test: reset");
    repeat (6) begin
      tick(OP_IDLE, '0);
      check_flag("o_valid", o_valid, 1'b0);
      check_flag("o_credit", o_credit, 1'b0);
    end
  endtask

  task automatic test_stream();
    $display("Test: ordered streaming");
    sink_mode = SINK_RETURN;
    for (int i = 0; i < 12; i++)
      send_word(data_t'(16'h1000 + i));
    drain();
  endtask

  task automatic test_backpressure();
    int start;
    $display("Test: back-pressure");
    start     = rx_count;
    stalls    = 0;
    sink_mode = SINK_HOLD;
    for (int i = 0; i < 16; i++)
      send_word(data_t'(16'h2000 + i));
    while (rx_count - start < OUT_CREDITS)
      tick(OP_IDLE, '0);
    idle(4);  // A word past the credit limit would show up here.
    check_count("words under back-pressure", clamp_count(rx_count - start),
                cred_cnt_t'(OUT_CREDITS));
    if (stalls != 0) begin
      errors++;
      $display("Source ran out of credits %0d times during back-pressure", stalls);
    end
    drain();
  endtask

  task automatic test_flush();
    int start;
    $display("Test: flush");
    start     = rx_count;
    sink_mode = SINK_HOLD;
    for (int i = 0; i < 10; i++)
      send_word(data_t'(16'h3000 + i));
    while (rx_count - start < OUT_CREDITS)
      tick(OP_IDLE, '0);
    idle(4);
    check_count("words before flush", clamp_count(rx_count - start), cred_cnt_t'(OUT_CREDITS));
    tick(OP_FLUSH, '0);
    start     = rx_count;
    sink_mode = SINK_RETURN;
    for (int i = 0; i < 6; i++)
      send_word(data_t'(16'h4000 + i));
    drain();
    check_count("words after flush", clamp_count(rx_count - start), cred_cnt_t'(6));
  endtask

  task automatic test_random();
    int gap;
    $display("Test: random traffic");
    sink_mode = SINK_RANDOM;
    for (int i = 0; i < 60; i++) begin
      gap = $urandom % 4;
      idle(gap);
      send_word(data_t'($urandom));
    end
    drain();
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      errors++;
      $display("Timeout after %0d cycles, the DUT stopped delivering words", MAX_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    int seed_ret;
    i_op        = OP_IDLE;
    i_data      = '0;
    i_credit    = 1'b0;
    src_credits = UP_CREDITS;
    sink_owed   = 0;
    sink_mode   = SINK_HOLD;
    rx_count    = 0;
    stalls      = 0;
    seed_ret    = $urandom(11187);
    @(posedge arst_n);
    test_reset();
    test_stream();
    test_backpressure();
    test_flush();
    test_random();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset is low from time zero and lifts on a falling edge.
  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;
  end

endmodule

// ==== verilog/lane_buffer_top.sv ====
`timescale 1ns/1ps

module lane_buffer_top (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  lane_pkg::op_e     i_op,
  input  lane_pkg::data_t   i_data,
  input  logic              i_credit,
  output logic              o_valid,
  output lane_pkg::data_t   o_data,
  output logic              o_credit
);

  import lane_pkg::*;

  logic [NUM_LANES-1:0] lane_push;
  logic [NUM_LANES-1:0] lane_pushed;
  logic [NUM_LANES-1:0] lane_pop;
  logic [NUM_LANES-1:0] lane_popped;
  data_t                lane_wdata;   // Shared write bus.
  data_t                lane_head [NUM_LANES];
  logic                 flush;

  stripe_distributor stripe_distributor_inst (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_op          (i_op),
    .i_data        (i_data),
    .i_lane_pushed (lane_pushed),
    .o_lane_push   (lane_push),
    .o_lane_data   (lane_wdata),
    .o_flush       (flush)
  );

  // Full and empty stay inside each lane, the acknowledges carry the result.
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    lane_fifo #(
      .WIDTH (DATA_W),
      .DEPTH (LANE_DEPTH)
    ) lane_fifo_inst (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_flush  (flush),
      .i_push   (lane_push[g]),
      .i_pop    (lane_pop[g]),
      .i_data   (lane_wdata),
      .o_data   (lane_head[g]),
      .o_empty  (),
      .o_full   (),
      .o_pushed (lane_pushed[g]),
      .o_popped (lane_popped[g])
    );
  end

  stripe_collector stripe_collector_inst (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_flush       (flush),
    .i_credit      (i_credit),
    .i_lane_data   (lane_head),
    .i_lane_popped (lane_popped),
    .o_lane_pop    (lane_pop),
    .o_valid       (o_valid),
    .o_data        (o_data),
    .o_credit      (o_credit)
  );

endmodule

// ==== verilog/stripe_collector.sv ====
`timescale 1ns/1ps

module stripe_collector (
  input  logic                             i_clk,
  input  logic                             i_arst_n,
  input  logic                             i_flush,
  input  logic                             i_credit,
  input  lane_pkg::data_t                  i_lane_data [lane_pkg::NUM_LANES],
  input  logic [lane_pkg::NUM_LANES-1:0]   i_lane_popped,
  output logic [lane_pkg::NUM_LANES-1:0]   o_lane_pop,
  output logic                             o_valid,
  output lane_pkg::data_t                  o_data,
  output logic                             o_credit
);

  import lane_pkg::*;

  logic [LANE_W-1:0] rd_lane_q;  // Lane holding the oldest word.
  cred_cnt_t         credits_q;
  logic              have_credit;
  logic              lane_ack;
  logic              pop_q;

  assign have_credit = (credits_q != '0);

  // Request a pop only from the lane next in order.
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++)
      o_lane_pop[i] = have_credit && (rd_lane_q == LANE_W'(i));
  end

  assign lane_ack = |(i_lane_popped & o_lane_pop);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_lane_q <= '0;
    end else if (i_flush) begin
      rd_lane_q <= '0;
    end else if (lane_ack) begin
      if (rd_lane_q == LANE_W'(NUM_LANES - 1))
        rd_lane_q <= '0;
      else
        rd_lane_q <= rd_lane_q + 1'b1;
    end
  end

  // Flush leaves the downstream credits alone.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      credits_q <= cred_cnt_t'(OUT_CREDITS);
    end else begin
      case ({lane_ack, i_credit})
        2'b10:   credits_q <= credits_q - 1'b1;  // Spent on a word.
        2'b01:   credits_q <= credits_q + 1'b1;  // Returned by the sink.
        default: credits_q <= credits_q;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n)
      pop_q <= 1'b0;
    else
      pop_q <= lane_ack;
  end

  always_ff @(posedge i_clk) begin
    if (lane_ack)
      o_data <= i_lane_data[rd_lane_q];
  end

  // Each word out also frees one upstream entry.
  assign o_valid  = pop_q;
  assign o_credit = pop_q;

  // An underflow from zero wraps above OUT_CREDITS and fails here as well.
  a_credit_max: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    credits_q <= cred_cnt_t'(OUT_CREDITS))
    else $error("credit counter outside 0 to OUT_CREDITS");

  a_pop_requested: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_lane_popped & ~o_lane_pop) == '0)
    else $error("lane popped without a request");

endmodule

// ==== verilog/stripe_distributor.sv ====
`timescale 1ns/1ps

module stripe_distributor (
  input  logic                             i_clk,
  input  logic                             i_arst_n,
  input  lane_pkg::op_e                    i_op,
  input  lane_pkg::data_t                  i_data,
  input  logic [lane_pkg::NUM_LANES-1:0]   i_lane_pushed,
  output logic [lane_pkg::NUM_LANES-1:0]   o_lane_push,
  output lane_pkg::data_t                  o_lane_data,
  output logic                             o_flush
);

  import lane_pkg::*;

  logic [LANE_W-1:0] wr_lane_q;  // Next lane to receive a word.
  logic              is_data;
  logic              lane_ack;

  // Opcode decode.
  always_comb begin
    is_data = 1'b0;
    o_flush = 1'b0;
    case (i_op)
      OP_DATA:  is_data = 1'b1;
      OP_FLUSH: o_flush = 1'b1;
      default:  ;  // Idle and the reserved code.
    endcase
  end

  // One-hot push toward the lane under the write pointer.
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++)
      o_lane_push[i] = is_data && (wr_lane_q == LANE_W'(i));
  end

  assign o_lane_data = i_data;  // Shared bus, only the pushed lane stores it.

  assign lane_ack = |(i_lane_pushed & o_lane_push);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_lane_q <= '0;
    end else if (o_flush) begin
      wr_lane_q <= '0;  // Restart striping at lane 0.
    end else if (lane_ack) begin
      if (wr_lane_q == LANE_W'(NUM_LANES - 1))
        wr_lane_q <= '0;
      else
        wr_lane_q <= wr_lane_q + 1'b1;
    end
  end

  // A refused DATA word means the source spent a credit it did not hold.
  a_data_accepted: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    is_data |-> lane_ack)
    else $error("DATA word not accepted by lane %0d", wr_lane_q);

endmodule

// ==== verilog/lane_fifo.sv ====
`timescale 1ns/1ps

module lane_fifo #(
  parameter int WIDTH = 16,  // Must be 1 or more.
  parameter int DEPTH = 4    // Must be 2 or more.
) (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_flush,
  input  logic             i_push,
  input  logic             i_pop,
  input  logic [WIDTH-1:0] i_data,
  output logic [WIDTH-1:0] o_data,
  output logic             o_empty,
  output logic             o_full,
  output logic             o_pushed,
  output logic             o_popped
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [WIDTH-1:0] entries [DEPTH];
  logic             do_push;
  logic             do_pop;

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  // Flush wins over both requests in its cycle.
  assign o_pushed = do_push && !i_flush;
  assign o_popped = do_pop && !i_flush;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (i_flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (o_pushed)
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;  // Wrap at depth.
      if (o_popped)
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_pushed)
      entries[wr_ptr_q] <= i_data;
  end

  assign o_data = entries[rd_ptr_q];  // Head word, no read latency.

  if (DEPTH < 4) begin : g_valid
    // Small lanes keep one valid bit per entry.
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] wr_vec;
    logic [DEPTH-1:0] rd_vec;

    always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
        wr_vec[i] = o_pushed && (wr_ptr_q == PTR_W'(i));
        rd_vec[i] = o_popped && (rd_ptr_q == PTR_W'(i));
      end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
        valid_q <= '0;
      else if (i_flush)
        valid_q <= '0;
      else
        valid_q <= (valid_q & ~rd_vec) | wr_vec;
    end

    assign o_empty = !(|valid_q);
    assign o_full  = &valid_q;
  end else begin : g_count
    // Deeper lanes count entries instead of reducing a wide vector.
    localparam int CNT_W = $clog2(DEPTH + 1);
    logic [CNT_W-1:0] count_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
        count_q <= '0;
      else if (i_flush)
        count_q <= '0;
      else if (o_pushed && !o_popped)
        count_q <= count_q + 1'b1;
      else if (!o_pushed && o_popped)
        count_q <= count_q - 1'b1;
    end

    assign o_empty = (count_q == '0);
    assign o_full  = (count_q == CNT_W'(DEPTH));

    a_occupancy: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      count_q <= CNT_W'(DEPTH))
      else $error("lane_fifo occupancy above depth");
  end

endmodule

// ==== verilog/lane_pkg.sv ====
package lane_pkg;

  // Lane geometry.
  localparam int NUM_LANES  = 4;
  localparam int LANE_DEPTH = 4;  // Entries per lane FIFO.
  localparam int LANE_W     = 2;  // Lane index width.

  localparam int DATA_W = 16;

  // Upstream side starts with one credit per buffer entry.
  localparam int UP_CREDITS = NUM_LANES * LANE_DEPTH;

  // Credits held by the collector for the downstream sink.
  localparam int OUT_CREDITS = 4;
  localparam int CRED_W      = 3;  // Must hold OUT_CREDITS.

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CRED_W-1:0] cred_cnt_t;

  // Upstream opcodes, code 2'b11 is reserved and decodes as idle.
  typedef enum logic [1:0] {
    OP_IDLE  = 2'b00,
    OP_DATA  = 2'b01,
    OP_FLUSH = 2'b10
  } op_e;

endpackage
